// File: include/boot_cfg.svh
`ifndef BOOT_CFG_SVH
`define BOOT_CFG_SVH

// Words copied from flash into SRAM at boot
`define BOOT_WORDS 32

// First flash word of the boot image
`define BOOT_FLASH_BASE 22'h010000

// Cycles with CE and OE low before the flash data is sampled
`define FLASH_WAIT 3

// SRAM word address width
`define RAM_AW 18

`endif

// File: verilog/boot_pkg.sv
`include "boot_cfg.svh"

package boot_pkg;

	// One SRAM access, read or write
	typedef struct packed {
		logic [`RAM_AW-1:0] addr;
		logic [15:0] data;
		logic write;
	} mem_req_t;

	typedef struct packed {
		logic [15:0] data;
	} mem_rsp_t;

	// Single word flash read
	typedef struct packed {
		logic [21:0] addr;
	} flash_req_t;

endpackage

// File: verilog/flash_ctrl.sv
`timescale 1ns/10ps
`include "boot_cfg.svh"

module flash_ctrl (
	input logic clk,
	input logic reset,
	input logic flash_req_valid,
	input boot_pkg::flash_req_t flash_req,
	output logic flash_req_ready,
	output logic flash_rsp_valid,
	output logic [15:0] flash_rsp_data,
	output logic [21:0] flash_addr,
	output logic flash_ce,
	output logic flash_oe,
	output logic flash_we,
	input logic [15:0] flash_rd_data
);
	localparam int WAIT_N = `FLASH_WAIT;
	localparam int CW = $clog2(WAIT_N + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_DONE
	} state_t;

	state_t state;
	logic [CW-1:0] wait_cnt;
	logic wait_last;

	assign wait_last = (wait_cnt == CW'(WAIT_N - 1));
	assign flash_req_ready = (state == S_IDLE);
	assign flash_rsp_valid = (state == S_DONE);

	// Read only, never programs the part
	assign flash_we = 1'b1;

	always_ff @(posedge clk) begin
		if (flash_req_valid && flash_req_ready)
			flash_addr <= flash_req.addr;
	end

	always_ff @(posedge clk) begin
		if (state == S_WAIT && wait_last)
			flash_rsp_data <= flash_rd_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			wait_cnt <= '0;
			flash_ce <= 1'b1;
			flash_oe <= 1'b1;
		end else begin
			case (state)
				S_IDLE: begin
					if (flash_req_valid) begin
						state <= S_WAIT;
						wait_cnt <= '0;
						flash_ce <= 1'b0;
						flash_oe <= 1'b0;
					end
				end
				S_WAIT: begin
					wait_cnt <= wait_cnt + 1'b1;
					// Data sampled on this edge, enables released
					if (wait_last) begin
						state <= S_DONE;
						flash_ce <= 1'b1;
						flash_oe <= 1'b1;
					end
				end
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/bootloader.sv
`timescale 1ns/10ps
`include "boot_cfg.svh"

module bootloader (
	input logic clk,
	input logic reset,
	output logic flash_req_valid,
	output boot_pkg::flash_req_t flash_req,
	input logic flash_req_ready,
	input logic flash_rsp_valid,
	input logic [15:0] flash_rsp_data,
	output logic boot_req_valid,
	output boot_pkg::mem_req_t boot_req,
	input logic boot_req_ready,
	output logic boot_done
);
	localparam int WORDS = `BOOT_WORDS;
	localparam int CW = $clog2(WORDS + 1);
	localparam int AW = `RAM_AW;

	typedef enum logic [1:0] {
		S_READ,
		S_WAIT,
		S_WRITE,
		S_DONE
	} state_t;

	state_t state;
	logic [CW-1:0] word_cnt;
	logic [15:0] word_q;
	logic last_word;

	assign last_word = (word_cnt == CW'(WORDS - 1));

	// Flash image is linear from the base, SRAM copy starts at zero
	assign flash_req_valid = (state == S_READ);
	assign flash_req = '{addr: `BOOT_FLASH_BASE + 22'(word_cnt)};

	assign boot_req_valid = (state == S_WRITE);
	assign boot_req = '{addr: AW'(word_cnt), data: word_q, write: 1'b1};

	assign boot_done = (state == S_DONE);

	always_ff @(posedge clk) begin
		if (flash_rsp_valid)
			word_q <= flash_rsp_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_READ;
			word_cnt <= '0;
		end else begin
			case (state)
				S_READ: begin
					if (flash_req_ready)
						state <= S_WAIT;
				end
				S_WAIT: begin
					if (flash_rsp_valid)
						state <= S_WRITE;
				end
				S_WRITE: begin
					if (boot_req_ready) begin
						if (last_word) begin
							state <= S_DONE;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state <= S_READ;
						end
					end
				end
				// Stays here until the next reset
				S_DONE: state <= S_DONE;
			endcase
		end
	end

endmodule

// File: verilog/ram_sel.sv
`timescale 1ns/10ps

module ram_sel (
	input logic clk,
	input logic reset,
	input logic boot_done,
	input logic boot_req_valid,
	input boot_pkg::mem_req_t boot_req,
	output logic boot_req_ready,
	input logic cpu_req_valid,
	input boot_pkg::mem_req_t cpu_req,
	output logic cpu_req_ready,
	output logic cpu_rsp_valid,
	output boot_pkg::mem_rsp_t cpu_rsp,
	output logic hold,
	output logic ram_req_valid,
	output boot_pkg::mem_req_t ram_req,
	input logic ram_req_ready,
	input logic ram_done,
	input boot_pkg::mem_rsp_t ram_rsp
);
	// Set while a processor read is in flight
	logic cpu_read_q;

	// Bootloader owns the SRAM until boot is done
	assign hold = !boot_done;
	assign boot_req_ready = !boot_done && ram_req_ready;
	assign cpu_req_ready = boot_done && ram_req_ready;

	assign ram_req_valid = boot_done ? cpu_req_valid : boot_req_valid;
	assign ram_req = boot_done ? cpu_req : boot_req;

	// Writes end silently, only reads answer
	assign cpu_rsp_valid = ram_done && cpu_read_q;
	assign cpu_rsp = ram_rsp;

	always_ff @(posedge clk) begin
		if (reset)
			cpu_read_q <= 1'b0;
		else if (cpu_req_valid && cpu_req_ready)
			cpu_read_q <= !cpu_req.write;
		else if (ram_done)
			cpu_read_q <= 1'b0;
	end

endmodule

// File: verilog/sram_ctrl.sv
`timescale 1ns/10ps
`include "boot_cfg.svh"

module sram_ctrl (
	input logic clk,
	input logic reset,
	input logic ram_req_valid,
	input boot_pkg::mem_req_t ram_req,
	output logic ram_req_ready,
	output logic ram_done,
	output boot_pkg::mem_rsp_t ram_rsp,
	output logic [`RAM_AW-1:0] ram_addr,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic ram_drive,
	output logic [15:0] ram_wr_data,
	input logic [15:0] ram_rd_data
);
	import boot_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACCESS,
		S_FINISH
	} state_t;

	state_t state;
	mem_req_t req_q;

	assign ram_req_ready = (state == S_IDLE);
	assign ram_done = (state == S_FINISH);

	// Address and data held for the whole access
	assign ram_addr = req_q.addr;
	assign ram_wr_data = req_q.data;

	always_ff @(posedge clk) begin
		if (ram_req_valid && ram_req_ready)
			req_q <= ram_req;
	end

	always_ff @(posedge clk) begin
		if (state == S_ACCESS && !req_q.write)
			ram_rsp <= '{data: ram_rd_data};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			ram_en <= 1'b1;
			ram_oe <= 1'b1;
			ram_we <= 1'b1;
			ram_drive <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (ram_req_valid) begin
						state <= S_ACCESS;
						ram_en <= 1'b0;
						ram_oe <= ram_req.write;
						ram_we <= !ram_req.write;
						ram_drive <= ram_req.write;
					end
				end
				// Write lands on the rising edge of WE, data still driven
				S_ACCESS: begin
					state <= S_FINISH;
					ram_oe <= 1'b1;
					ram_we <= 1'b1;
				end
				S_FINISH: begin
					state <= S_IDLE;
					ram_en <= 1'b1;
					ram_drive <= 1'b0;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/boot_mem_top.sv
`timescale 1ns/10ps
`include "boot_cfg.svh"

module boot_mem_top (
	input logic clk,
	input logic reset,
	input logic cpu_req_valid,
	output logic cpu_req_ready,
	input boot_pkg::mem_req_t cpu_req,
	output logic cpu_rsp_valid,
	output boot_pkg::mem_rsp_t cpu_rsp,
	output logic hold,
	output logic boot_done,
	output logic [21:0] flash_addr,
	output logic flash_ce,
	output logic flash_oe,
	output logic flash_we,
	input logic [15:0] flash_rd_data,
	output logic [`RAM_AW-1:0] ram_addr,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic [15:0] ram_wr_data,
	output logic ram_drive,
	input logic [15:0] ram_rd_data
);
	import boot_pkg::*;

// Bootloader and flash
	logic flash_req_valid;
	logic flash_req_ready;
	flash_req_t flash_req;
	logic flash_rsp_valid;
	logic [15:0] flash_rsp_data;
	logic boot_req_valid;
	logic boot_req_ready;
	mem_req_t boot_req;

	bootloader __bootloader(
		.clk(clk),
		.reset(reset),
		.flash_req_valid(flash_req_valid),
		.flash_req(flash_req),
		.flash_req_ready(flash_req_ready),
		.flash_rsp_valid(flash_rsp_valid),
		.flash_rsp_data(flash_rsp_data),
		.boot_req_valid(boot_req_valid),
		.boot_req(boot_req),
		.boot_req_ready(boot_req_ready),
		.boot_done(boot_done)
	);

	flash_ctrl __flash_ctrl(
		.clk(clk),
		.reset(reset),
		.flash_req_valid(flash_req_valid),
		.flash_req(flash_req),
		.flash_req_ready(flash_req_ready),
		.flash_rsp_valid(flash_rsp_valid),
		.flash_rsp_data(flash_rsp_data),
		.flash_addr(flash_addr),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.flash_we(flash_we),
		.flash_rd_data(flash_rd_data)
	);

// SRAM path
	logic ram_req_valid;
	logic ram_req_ready;
	mem_req_t ram_req;
	logic ram_done;
	mem_rsp_t ram_rsp;

	ram_sel __ram_sel(
		.clk(clk),
		.reset(reset),
		.boot_done(boot_done),
		.boot_req_valid(boot_req_valid),
		.boot_req(boot_req),
		.boot_req_ready(boot_req_ready),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req(cpu_req),
		.cpu_req_ready(cpu_req_ready),
		.cpu_rsp_valid(cpu_rsp_valid),
		.cpu_rsp(cpu_rsp),
		.hold(hold),
		.ram_req_valid(ram_req_valid),
		.ram_req(ram_req),
		.ram_req_ready(ram_req_ready),
		.ram_done(ram_done),
		.ram_rsp(ram_rsp)
	);

	sram_ctrl __sram_ctrl(
		.clk(clk),
		.reset(reset),
		.ram_req_valid(ram_req_valid),
		.ram_req(ram_req),
		.ram_req_ready(ram_req_ready),
		.ram_done(ram_done),
		.ram_rsp(ram_rsp),
		.ram_addr(ram_addr),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.ram_drive(ram_drive),
		.ram_wr_data(ram_wr_data),
		.ram_rd_data(ram_rd_data)
	);

endmodule

// File: tests/tb_mem_models.sv
`timescale 1ns/10ps
`include "boot_cfg.svh"

// Parallel NOR flash, read only
module flash_model (
	input logic clk,
	input logic [21:0] flash_addr,
	input logic flash_ce,
	input logic flash_oe,
	input logic flash_we,
	output logic [15:0] flash_rd_data
);
	// Data settles one cycle before the controller samples it
	localparam int LAT = `FLASH_WAIT - 1;

	int cnt;

	always @(posedge clk) begin
		if (!flash_ce && !flash_oe)
			cnt <= cnt + 1;
		else
			cnt <= 0;
	end

	// Upper address bits folded into the low half
	assign flash_rd_data = (!flash_ce && !flash_oe && flash_we && cnt >= LAT) ?
		(flash_addr[15:0] ^ {10'b0, flash_addr[21:16]} ^ 16'hA5C3) : 16'hFFFF;

endmodule

// Asynchronous SRAM, one word per address
module sram_model (
	input logic clk,
	input logic [`RAM_AW-1:0] ram_addr,
	input logic ram_en,
	input logic ram_oe,
	input logic ram_we,
	input logic ram_drive,
	input logic [15:0] ram_wr_data,
	output logic [15:0] ram_rd_data
);
	logic [15:0] mem [0:(1 << `RAM_AW) - 1];

	// Write taken while WE is low and the bus is driven
	always @(posedge clk) begin
		if (!ram_en && !ram_we && ram_drive)
			mem[ram_addr] <= ram_wr_data;
	end

	assign ram_rd_data = (!ram_en && !ram_oe) ? mem[ram_addr] : 16'hFFFF;

endmodule

// File: tests/tb_boot_mem.sv
`timescale 1ns/10ps
`include "boot_cfg.svh"

module tb_boot_mem;
	import boot_pkg::*;

	localparam int WORDS = `BOOT_WORDS;
	localparam int AW = `RAM_AW;
	localparam int LIMIT = WORDS * (`FLASH_WAIT + 8) + 200;
	localparam int PAIRS = 8;

	logic clk = 1'b0;
	logic reset;
	logic cpu_req_valid;
	logic cpu_req_ready;
	mem_req_t cpu_req;
	logic cpu_rsp_valid;
	mem_rsp_t cpu_rsp;
	logic hold;
	logic boot_done;
	logic [21:0] flash_addr;
	logic flash_ce;
	logic flash_oe;
	logic flash_we;
	logic [15:0] flash_rd_data;
	logic [AW-1:0] ram_addr;
	logic ram_en;
	logic ram_oe;
	logic ram_we;
	logic [15:0] ram_wr_data;
	logic ram_drive;
	logic [15:0] ram_rd_data;

	logic rd_acc;
	logic [15:0] exp_data;
	logic [AW-1:0] acc_addr;
	int errors = 0;
	int seed = 97;

	always #5 clk = !clk;

	boot_mem_top dut_i (.*);
	flash_model flash_i (.*);
	sram_model sram_i (.*);

	assign rd_acc = cpu_req_valid && cpu_req_ready && !cpu_req.write;

	// Last processor address taken by the DUT
	always @(posedge clk) begin
		if (cpu_req_valid && cpu_req_ready)
			acc_addr <= cpu_req.addr;
	end

	function automatic logic [15:0] flash_pattern(input logic [21:0] a);
		return a[15:0] ^ {10'b0, a[21:16]} ^ 16'hA5C3;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("ERR %0t %s got %0h expected %0h", $time, name, got, want);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("Check failed at %0t: %s", $time, msg);
	endtask

	// Bus state on the first cycle out of reset
	a_rst_flash: assert property (@(posedge clk)
		$fell(reset) |-> {flash_ce, flash_oe, flash_we} == 3'b111)
		else report_mismatch("{flash_ce,flash_oe,flash_we}",
			$sampled({flash_ce, flash_oe, flash_we}), 3'b111);
	a_rst_ram: assert property (@(posedge clk)
		$fell(reset) |-> {ram_en, ram_oe, ram_we, ram_drive} == 4'b1110)
		else report_mismatch("{ram_en,ram_oe,ram_we,ram_drive}",
			$sampled({ram_en, ram_oe, ram_we, ram_drive}), 4'b1110);
	a_rst_ctl: assert property (@(posedge clk)
		$fell(reset) |-> {cpu_req_ready, cpu_rsp_valid, boot_done, hold} == 4'b0001)
		else report_mismatch("{cpu_req_ready,cpu_rsp_valid,boot_done,hold}",
			$sampled({cpu_req_ready, cpu_rsp_valid, boot_done, hold}), 4'b0001);

	// Processor locked out during boot
	a_boot_hold: assert property (@(posedge clk) disable iff (reset)
		!boot_done |-> {hold, cpu_req_ready} == 2'b10)
		else report_mismatch("{hold,cpu_req_ready}",
			$sampled({hold, cpu_req_ready}), 2'b10);
	a_done_stays: assert property (@(posedge clk) disable iff (reset)
		$past(boot_done) |-> boot_done)
		else report_mismatch("boot_done", $sampled(boot_done), 1'b1);
	a_done_state: assert property (@(posedge clk) disable iff (reset)
		boot_done |-> {hold, flash_ce} == 2'b01)
		else report_mismatch("{hold,flash_ce}", $sampled({hold, flash_ce}), 2'b01);

	// SRAM bus carries the accepted processor address
	a_ram_addr: assert property (@(posedge clk) disable iff (reset)
		$past(cpu_req_valid && cpu_req_ready) |-> ram_addr == acc_addr)
		else report_mismatch("ram_addr", $sampled(ram_addr), acc_addr);

	// Read response timing and data
	a_rsp_time: assert property (@(posedge clk) disable iff (reset)
		$past(rd_acc, 2) |-> cpu_rsp_valid)
		else report_failure("no read response 2 cycles after the read was accepted");
	a_rsp_only_read: assert property (@(posedge clk) disable iff (reset)
		cpu_rsp_valid |-> $past(rd_acc, 2))
		else report_failure("cpu_rsp_valid without a read accepted 2 cycles earlier");
	a_rsp_data: assert property (@(posedge clk) disable iff (reset)
		cpu_rsp_valid |-> cpu_rsp.data == exp_data)
		else report_mismatch("cpu_rsp.data", $sampled(cpu_rsp.data), exp_data);

	// Called 1 ns after a rising edge, returns 1 ns after the last edge it needs
	task automatic cpu_access(input logic [AW-1:0] addr, input logic [15:0] data,
		input logic write, input logic [15:0] rd_exp);
		cpu_req = '{addr: addr, data: data, write: write};
		cpu_req_valid = 1'b1;
		exp_data = rd_exp;
		@(negedge clk);
		while (!cpu_req_ready)
			@(negedge clk);
		@(posedge clk);
		#1 cpu_req_valid = 1'b0;
		if (!write) begin
			@(negedge clk);
			while (!cpu_rsp_valid)
				@(negedge clk);
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		logic [AW-1:0] addr;
		logic [15:0] data;
		reset = 1'b1;
		cpu_req_valid = 1'b0;
		cpu_req = '0;
		exp_data = '0;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		// First read is offered at once and stalls through the whole boot
		for (int i = 0; i < WORDS; i++)
			cpu_access(AW'(i), 16'h0, 1'b0, flash_pattern(`BOOT_FLASH_BASE + 22'(i)));
		for (int i = 0; i < PAIRS; i++) begin
			addr = AW'(WORDS + $unsigned($random(seed)) % ((1 << AW) - WORDS));
			data = 16'($random(seed));
			cpu_access(addr, data, 1'b1, 16'h0);
			cpu_access(addr, 16'h0, 1'b0, data);
		end
		repeat (3) @(posedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("Timeout: run did not end within %0d cycles, errors %0d", LIMIT, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: boot_mem_top.f
+incdir+include
verilog/boot_pkg.sv
verilog/flash_ctrl.sv
verilog/bootloader.sv
verilog/ram_sel.sv
verilog/sram_ctrl.sv
verilog/boot_mem_top.sv
tests/tb_mem_models.sv
tests/tb_boot_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f boot_mem_top.f \
	--top-module tb_boot_mem \
	-Mdir obj_dir -o tb_boot_mem

./obj_dir/tb_boot_mem | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
	echo "run_sim: testbench passed"
	exit 0
fi
echo "run_sim: testbench failed, see sim.log"
exit 1
